// File: Makefile
# Verilator build and run of the board I/O testbench
SRCS := build.f $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vboard_io_tb: $(SRCS)
	verilator --binary --timing --assert --top-module board_io_tb -f build.f

run: obj_dir/Vboard_io_tb
	./obj_dir/Vboard_io_tb | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: build.f
+incdir+verilog
verilog/cr_pkg.sv
verilog/kbd_if.sv
verilog/kbd_fifo.sv
verilog/cr_mem.sv
verilog/seg7_digit.sv
verilog/seg7_scan.sv
verilog/board_io_top.sv
tb/board_io_tb.sv

// File: tb/board_io_tb.sv
// Needs Verilator --timing and --assert; keyboard test assumes the queue holds at most five bytes
`timescale 1ns/10ps
`default_nettype none

`include "cr_params.svh"

module board_io_tb;

    localparam int N     = `SEG7_DIGITS;
    localparam int IDX_W = $clog2(N);
    localparam int DEPTH = `KBD_FIFO_DEPTH;

    // Seven-segment font, active high, bit 0 is segment a
    localparam logic [6:0] FONT [0:15] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    // DUT ports
    logic         clk;
    logic         rst_n;
    logic [31:0]  address;
    logic [31:0]  data;
    logic         wren;
    logic         rden;
    logic [31:0]  q;
    logic [31:0]  address_b;
    logic [31:0]  q_b;
    logic         button_0;
    logic         button_1;
    logic [9:0]   switch;
    logic [11:0]  joystick_x;
    logic [11:0]  joystick_y;
    logic [7:0]   kbd_byte;
    logic         kbd_valid;
    logic [9:0]   led;
    logic [7:0]   seg_n;
    logic [N-1:0] an_n;

    // Check enables and expected values, all changed on falling edges
    logic         chk_rst;
    logic         chk_q;
    logic         chk_led;
    logic         chk_seg;
    logic [31:0]  exp_q;
    logic [9:0]   exp_led;
    logic [7:0]   exp_pat [0:N-1];
    logic [N-1:0] seen;
    logic [IDX_W-1:0] an_idx;

    // Reference model state
    logic [7:0]   kbd_model [$];
    logic [31:0]  rng;

    // Bookkeeping
    int errors;
    int timeouts;
    int tests_run;
    int tests_failed;
    int mark;

    board_io_top dut_i (
        .Clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .data       (data),
        .wren       (wren),
        .rden       (rden),
        .q          (q),
        .address_b  (address_b),
        .q_b        (q_b),
        .button_0   (button_0),
        .button_1   (button_1),
        .switch     (switch),
        .joystick_x (joystick_x),
        .joystick_y (joystick_y),
        .kbd_byte   (kbd_byte),
        .kbd_valid  (kbd_valid),
        .led        (led),
        .seg_n      (seg_n),
        .an_n       (an_n)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // Digit currently selected by the anodes
    always_comb begin
        an_idx = '0;
        for (int i = 0; i < N; i++) begin
            if (!an_n[i]) begin
                an_idx = IDX_W'(i);
            end
        end
    end

    // Digits the scanner has shown while checking
    always @(posedge clk) begin
        if (!chk_seg) begin
            seen <= '0;
        end else if ($onehot(~an_n)) begin
            seen[an_idx] <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------
    a_reset: assert property (@(posedge clk)
        chk_rst |-> (led == '0 && q == '0 && q_b == '0 && seg_n == 8'hFF && an_n == '1))
        else begin
            errors++;
            $display("MISMATCH at %0t: outputs not at their reset values", $time);
        end

    // Both read ports return the same word
    a_core: assert property (@(posedge clk) disable iff (!rst_n)
        chk_q |-> (q == exp_q))
        else begin
            errors++;
            $display("MISMATCH at %0t: q = %h, expected %h", $time, $sampled(q), exp_q);
        end

    a_fabric: assert property (@(posedge clk) disable iff (!rst_n)
        chk_q |-> (q_b == exp_q))
        else begin
            errors++;
            $display("MISMATCH at %0t: q_b = %h, expected %h", $time, $sampled(q_b), exp_q);
        end

    a_led: assert property (@(posedge clk) disable iff (!rst_n)
        chk_led |-> (led == exp_led))
        else begin
            errors++;
            $display("MISMATCH at %0t: led = %h, expected %h", $time, $sampled(led), exp_led);
        end

    // One anode low, segments match that digit
    a_display: assert property (@(posedge clk) disable iff (!rst_n)
        chk_seg |-> ($onehot(~an_n) && seg_n == exp_pat[an_idx]))
        else begin
            errors++;
            $display("MISMATCH at %0t: an_n = %b, seg_n = %h, expected %h", $time,
                     $sampled(an_n), $sampled(seg_n), exp_pat[$sampled(an_idx)]);
        end

    // ------------------------------------------------------------
    // Model and stimulus helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Raw mode inverts segments, hex mode uses the font and point
    function automatic logic [7:0] seg_pattern(input logic [7:0] cr);
        logic [7:0] pat;
        if (cr[7]) begin
            pat = {1'b1, ~cr[6:0]};
        end else begin
            pat = {~cr[4], ~FONT[cr[3:0]]};
        end
        return pat;
    endfunction

    // All tasks start and end on a falling edge
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] value);
        address = addr;
        data    = value;
        wren    = 1'b1;
        @(negedge clk);
        wren    = 1'b0;
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] value);
        address   = addr;
        address_b = addr;
        rden      = 1'b1;
        @(negedge clk);
        rden  = 1'b0;
        exp_q = value;
        chk_q = 1'b1;
        @(negedge clk);
        chk_q = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b);
        kbd_byte  = b;
        kbd_valid = 1'b1;
        @(negedge clk);
        kbd_valid = 1'b0;
    endtask

    task automatic start_test();
        mark = errors + timeouts;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors + timeouts != mark) begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [7:0] b;
        logic [7:0] digit;
        int         n;
        clk        = 1'b0;
        rst_n      = 1'b0;
        address    = '0;
        data       = '0;
        wren       = 1'b0;
        rden       = 1'b0;
        address_b  = '0;
        button_0   = 1'b0;
        button_1   = 1'b0;
        switch     = '0;
        joystick_x = '0;
        joystick_y = '0;
        kbd_byte   = '0;
        kbd_valid  = 1'b0;
        chk_rst    = 1'b0;
        chk_q      = 1'b0;
        chk_led    = 1'b0;
        chk_seg    = 1'b0;
        exp_q      = '0;
        exp_led    = '0;
        for (int i = 0; i < N; i++) begin
            exp_pat[IDX_W'(i)] = 8'hFF;
        end
        rng          = 32'd65967;
        errors       = 0;
        timeouts     = 0;
        tests_run    = 0;
        tests_failed = 0;

        // Reset held for four cycles, outputs checked on the last three
        start_test();
        @(negedge clk);
        chk_rst = 1'b1;
        repeat (3) @(negedge clk);
        chk_rst = 1'b0;
        rst_n   = 1'b1;
        read_check(`CR_KBD_READY, 32'd0);
        finish_test("reset");

        // LED write, upper data bits random and ignored
        start_test();
        rng     = xorshift(rng);
        // Old value on the two edges after the write, new from the third
        chk_led = 1'b1;
        write_reg(`CR_LED, rng);
        repeat (2) @(negedge clk);
        exp_led = rng[9:0];
        repeat (2) @(negedge clk);
        chk_led = 1'b0;
        read_check(`CR_LED, {22'b0, exp_led});
        read_check(32'h0000_0040, 32'd0);
        read_check(32'h0000_1018, 32'd0);
        finish_test("led");

        // Board inputs held past the synchroniser
        start_test();
        rng        = xorshift(rng);
        switch     = rng[9:0];
        button_0   = rng[10];
        button_1   = rng[11];
        joystick_x = rng[23:12];
        rng        = xorshift(rng);
        joystick_y = rng[11:0];
        repeat (4) @(negedge clk);
        read_check(`CR_SWITCH, {22'b0, switch});
        read_check(`CR_BUTTON_0, {31'b0, button_0});
        read_check(`CR_BUTTON_1, {31'b0, button_1});
        read_check(`CR_JOYSTICK_X, {20'b0, joystick_x});
        read_check(`CR_JOYSTICK_Y, {20'b0, joystick_y});
        finish_test("inputs");

        // Even digits raw, odd digits hex
        start_test();
        for (int i = 0; i < N; i++) begin
            rng   = xorshift(rng);
            digit = {~i[0], rng[6:0]};
            exp_pat[IDX_W'(i)] = seg_pattern(digit);
            write_reg(`CR_SEG7_0 + 32'(4 * i), {rng[31:8], digit});
            read_check(`CR_SEG7_0 + 32'(4 * i), {24'b0, digit});
        end
        // Register, two output stages, encoder, scanner
        repeat (6) @(negedge clk);
        chk_seg = 1'b1;
        n = 0;
        while (seen != {N{1'b1}} && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (seen != {N{1'b1}}) begin
            timeouts++;
            $display("display scan did not select every digit within 100 cycles");
        end
        chk_seg = 1'b0;
        finish_test("display");

        // Scan still disabled from reset
        start_test();
        rng = xorshift(rng);
        send_byte(rng[7:0]);
        send_byte(rng[15:8]);
        read_check(`CR_KBD_SCANF_EN, 32'd0);
        read_check(`CR_KBD_READY, 32'd0);
        finish_test("kbd_gating");

        // Five bytes offered, queue keeps the first DEPTH
        start_test();
        write_reg(`CR_KBD_SCANF_EN, 32'd1);
        read_check(`CR_KBD_SCANF_EN, 32'd1);
        for (int i = 0; i < 5; i++) begin
            rng = xorshift(rng);
            b   = rng[7:0];
            if (kbd_model.size() < DEPTH) begin
                kbd_model.push_back(b);
            end
            send_byte(b);
        end
        read_check(`CR_KBD_READY, 32'd1);
        while (kbd_model.size() > 0) begin
            b = kbd_model.pop_front();
            read_check(`CR_KBD_DATA, {24'b0, b});
        end
        read_check(`CR_KBD_READY, 32'd0);
        finish_test("kbd_order");

        $display("tests run %0d, failed %0d, assertion errors %0d, timeouts %0d",
                 tests_run, tests_failed, errors, timeouts);
        if (errors == 0 && timeouts == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/board_io_top.sv
// Core port reads are one cycle latent and pop the keyboard queue; the fabric port is read-only
`timescale 1ns/10ps
`default_nettype none

`include "cr_params.svh"

module board_io_top
    import cr_pkg::*;
(
    input  logic                    Clk,
    input  logic                    rst_n,
    // Core load/store port
    input  logic [31:0]             address,
    input  logic [31:0]             data,
    input  logic                    wren,
    input  logic                    rden,
    output logic [31:0]             q,
    // Fabric read port
    input  logic [31:0]             address_b,
    output logic [31:0]             q_b,
    // Board inputs
    input  logic                    button_0,
    input  logic                    button_1,
    input  logic [9:0]              switch,
    input  logic [11:0]             joystick_x,
    input  logic [11:0]             joystick_y,
    // Assembled keyboard bytes
    input  logic [7:0]              kbd_byte,
    input  logic                    kbd_valid,
    // Board outputs
    output logic [9:0]              led,
    output logic [7:0]              seg_n,
    output logic [`SEG7_DIGITS-1:0] an_n
);

    kbd_if kbd ();

    // Digit registers after the output pipeline
    t_seg7_cr   digits      [0:`SEG7_DIGITS-1];
    // Per-digit encoded patterns
    logic [7:0] digit_seg_n [0:`SEG7_DIGITS-1];

    cr_mem u_cr_mem (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .address    (address),
        .data       (data),
        .wren       (wren),
        .rden       (rden),
        .q          (q),
        .address_b  (address_b),
        .q_b        (q_b),
        .button_0   (button_0),
        .button_1   (button_1),
        .switch     (switch),
        .joystick_x (joystick_x),
        .joystick_y (joystick_y),
        .kbd        (kbd.cr_side),
        .led        (led),
        .digits     (digits)
    );

    kbd_fifo u_kbd_fifo (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .kbd_byte  (kbd_byte),
        .kbd_valid (kbd_valid),
        .kbd       (kbd.fifo_side)
    );

    // One encoder per digit
    for (genvar i = 0; i < `SEG7_DIGITS; i++) begin : g_digit
        seg7_digit u_seg7_digit (
            .Clk   (Clk),
            .rst_n (rst_n),
            .cr    (digits[i]),
            .seg_n (digit_seg_n[i])
        );
    end

    seg7_scan u_seg7_scan (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .digit_seg_n (digit_seg_n),
        .seg_n       (seg_n),
        .an_n        (an_n)
    );

endmodule

`default_nettype wire

// File: verilog/cr_mem.sv
// Reads return zero for unmapped offsets; board inputs are up to three cycles stale when read
`timescale 1ns/10ps
`default_nettype none

`include "cr_params.svh"

module cr_mem
    import cr_pkg::*;
(
    input  logic        Clk,
    input  logic        rst_n,
    // Core load/store port
    input  logic [31:0] address,
    input  logic [31:0] data,
    input  logic        wren,
    input  logic        rden,
    output logic [31:0] q,
    // Fabric read port, always enabled
    input  logic [31:0] address_b,
    output logic [31:0] q_b,
    // Asynchronous board inputs
    input  logic        button_0,
    input  logic        button_1,
    input  logic [9:0]  switch,
    input  logic [11:0] joystick_x,
    input  logic [11:0] joystick_y,
    kbd_if.cr_side      kbd,
    // Pipelined board outputs
    output logic [9:0]  led,
    output t_seg7_cr    digits [0:`SEG7_DIGITS-1]
);

    // Writable registers
    t_seg7_cr    seg7_r [0:`SEG7_DIGITS-1];
    logic [9:0]  led_r;
    logic        scan_en_r;

    // Two-flop synchroniser, packed as button_0, button_1, switch, x, y
    logic [35:0] in_s1;
    logic [35:0] in_s2;

    // First output stage
    logic [9:0]  led_p1;
    t_seg7_cr    seg7_p1 [0:`SEG7_DIGITS-1];

    // ------------------------------------------------------------
    // Core writes
    // ------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `SEG7_DIGITS; i++) begin
                seg7_r[i] <= '0;
            end
            led_r     <= '0;
            scan_en_r <= 1'b0;
        end else if (wren) begin
            case (address)
                `CR_SEG7_0:       seg7_r[0] <= data[7:0];
                `CR_SEG7_1:       seg7_r[1] <= data[7:0];
                `CR_SEG7_2:       seg7_r[2] <= data[7:0];
                `CR_SEG7_3:       seg7_r[3] <= data[7:0];
                `CR_SEG7_4:       seg7_r[4] <= data[7:0];
                `CR_SEG7_5:       seg7_r[5] <= data[7:0];
                `CR_LED:          led_r     <= data[9:0];
                `CR_KBD_SCANF_EN: scan_en_r <= data[0];
                // Read-only and unmapped offsets ignore writes
                default: ;
            endcase
        end
    end

    // Input sync, payload only
    always_ff @(posedge Clk) begin
        in_s1 <= {button_0, button_1, switch, joystick_x, joystick_y};
        in_s2 <= in_s1;
    end

    // ------------------------------------------------------------
    // Read decode, shared by both ports
    // ------------------------------------------------------------
    function automatic logic [31:0] read_mux(input logic [31:0] addr);
        logic [31:0] rd;
        rd = 32'b0;
        case (addr)
            `CR_SEG7_0:       rd = {24'b0, seg7_r[0]};
            `CR_SEG7_1:       rd = {24'b0, seg7_r[1]};
            `CR_SEG7_2:       rd = {24'b0, seg7_r[2]};
            `CR_SEG7_3:       rd = {24'b0, seg7_r[3]};
            `CR_SEG7_4:       rd = {24'b0, seg7_r[4]};
            `CR_SEG7_5:       rd = {24'b0, seg7_r[5]};
            `CR_LED:          rd = {22'b0, led_r};
            `CR_KBD_SCANF_EN: rd = {31'b0, scan_en_r};
            // Synchronised inputs
            `CR_BUTTON_0:     rd = {31'b0, in_s2[35]};
            `CR_BUTTON_1:     rd = {31'b0, in_s2[34]};
            `CR_SWITCH:       rd = {22'b0, in_s2[33:24]};
            `CR_JOYSTICK_X:   rd = {20'b0, in_s2[23:12]};
            `CR_JOYSTICK_Y:   rd = {20'b0, in_s2[11:0]};
            // Live queue state, head byte taken as it is popped
            `CR_KBD_READY:    rd = {31'b0, kbd.kbd_ready};
            `CR_KBD_DATA:     rd = {24'b0, kbd.kbd_data};
            default:          rd = 32'b0;
        endcase
        return rd;
    endfunction

    // One-cycle read latency on both ports
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            q   <= '0;
            q_b <= '0;
        end else begin
            q   <= rden ? read_mux(address) : 32'b0;
            q_b <= read_mux(address_b);
        end
    end

    // Core read of the data register pops the head
    // Fabric reads never pop
    assign kbd.kbd_pop      = rden && (address == `CR_KBD_DATA);
    assign kbd.kbd_scanf_en = scan_en_r;

    // ------------------------------------------------------------
    // Output pipeline, two stages after the register
    // ------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            led_p1 <= '0;
            led    <= '0;
            for (int i = 0; i < `SEG7_DIGITS; i++) begin
                seg7_p1[i] <= '0;
                digits[i]  <= '0;
            end
        end else begin
            led_p1 <= led_r;
            led    <= led_p1;
            for (int i = 0; i < `SEG7_DIGITS; i++) begin
                seg7_p1[i] <= seg7_r[i];
                digits[i]  <= seg7_p1[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/cr_params.svh
// Offsets are byte addresses of 32-bit words; KBD_FIFO_DEPTH must be a power of two
`ifndef CR_PARAMS_SVH
`define CR_PARAMS_SVH

// ------------------------------------------------------------
// Register map, compared against core and fabric addresses
// ------------------------------------------------------------

// Digit registers, one per display position
`define CR_SEG7_0        32'h0000_0000
`define CR_SEG7_1        32'h0000_0004
`define CR_SEG7_2        32'h0000_0008
`define CR_SEG7_3        32'h0000_000C
`define CR_SEG7_4        32'h0000_0010
`define CR_SEG7_5        32'h0000_0014
// Writable control
`define CR_LED           32'h0000_0018
`define CR_KBD_SCANF_EN  32'h0000_001C
// Read-only board inputs
`define CR_BUTTON_0      32'h0000_0020
`define CR_BUTTON_1      32'h0000_0024
`define CR_SWITCH        32'h0000_0028
`define CR_JOYSTICK_X    32'h0000_002C
`define CR_JOYSTICK_Y    32'h0000_0030
// Keyboard queue status and head byte
`define CR_KBD_READY     32'h0000_0034
`define CR_KBD_DATA      32'h0000_0038

// ------------------------------------------------------------
// Sizing
// ------------------------------------------------------------

// Byte entries in the keyboard queue
`define KBD_FIFO_DEPTH   4
// Digits on the shared display bus
`define SEG7_DIGITS      6
// Clocks each digit stays lit
`define SCAN_DIV         4

`endif

// File: verilog/cr_pkg.sv
// Digit register types only; bit 7 of every digit byte selects raw (1) or hex (0) decoding
`default_nettype none

package cr_pkg;

    // ------------------------------------------------------------
    // Digit register, raw view
    // ------------------------------------------------------------
    // Segment bits: seg[0] is a, seg[6] is g
    // 1 lights the segment
    typedef struct packed {
        logic       mode;
        logic [6:0] seg;
    } t_seg7_raw;

    // ------------------------------------------------------------
    // Digit register, hex view
    // ------------------------------------------------------------
    // Mode flag clear in this view
    // Spare bits ignored by the encoder
    typedef struct packed {
        logic       mode;
        logic [1:0] spare;
        logic       dp;
        logic [3:0] value;
    } t_seg7_hex;

    // One stored byte, two readings
    // Mode bit sits at the same place in both views
    typedef union packed {
        t_seg7_raw raw;
        t_seg7_hex hex;
    } t_seg7_cr;

endpackage

`default_nettype wire

// File: verilog/kbd_fifo.sv
// Bytes arriving while full or with scan disabled are dropped; head byte is undefined when empty
`timescale 1ns/10ps
`default_nettype none

`include "cr_params.svh"

module kbd_fifo (
    input  logic       Clk,
    input  logic       rst_n,
    // Assembled bytes from the keyboard front end
    input  logic [7:0] kbd_byte,
    input  logic       kbd_valid,
    kbd_if.fifo_side   kbd
);

    localparam int DEPTH = `KBD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL = (PTR_W+1)'(DEPTH);

    // Byte storage
    logic [7:0]       mem [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // One bit wider than the pointers to tell full from empty
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    // Gated push, back-pressure by dropping
    assign push = kbd_valid && kbd.kbd_scanf_en && (count != FULL);
    assign pop  = kbd.kbd_pop && (count != '0);

    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wr_ptr] <= kbd_byte;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // Both or neither, level unchanged
                default: count <= count;
            endcase
        end
    end

    // Head byte and ready level straight from the state
    assign kbd.kbd_data  = mem[rd_ptr];
    assign kbd.kbd_ready = (count != '0);

endmodule

`default_nettype wire

// File: verilog/kbd_if.sv
// Keyboard queue link; pop is a single-cycle strobe, scan enable is a level
`timescale 1ns/10ps
`default_nettype none

interface kbd_if;

    // Head byte of the queue
    logic [7:0] kbd_data;
    // Queue holds at least one byte
    logic       kbd_ready;
    // Remove head byte, ignored when empty
    logic       kbd_pop;
    // Accept bytes from the keyboard front end
    logic       kbd_scanf_en;

    // Queue end
    modport fifo_side (
        output kbd_data,
        output kbd_ready,
        input  kbd_pop,
        input  kbd_scanf_en
    );

    // Register block end
    modport cr_side (
        input  kbd_data,
        input  kbd_ready,
        output kbd_pop,
        output kbd_scanf_en
    );

endinterface

`default_nettype wire

// File: verilog/seg7_digit.sv
// Output is active low as {dp, g..a} and lags the digit register by one cycle
`timescale 1ns/10ps
`default_nettype none

module seg7_digit
    import cr_pkg::*;
(
    input  logic       Clk,
    input  logic       rst_n,
    input  t_seg7_cr   cr,
    output logic [7:0] seg_n
);

    // Hex font, active high, bit 0 is segment a
    function automatic logic [6:0] hex_font(input logic [3:0] value);
        logic [6:0] seg;
        case (value)
            4'h0:    seg = 7'h3F;
            4'h1:    seg = 7'h06;
            4'h2:    seg = 7'h5B;
            4'h3:    seg = 7'h4F;
            4'h4:    seg = 7'h66;
            4'h5:    seg = 7'h6D;
            4'h6:    seg = 7'h7D;
            4'h7:    seg = 7'h07;
            4'h8:    seg = 7'h7F;
            4'h9:    seg = 7'h6F;
            4'hA:    seg = 7'h77;
            // Lower case b and d keep them apart from 8 and 0
            4'hB:    seg = 7'h7C;
            4'hC:    seg = 7'h39;
            4'hD:    seg = 7'h5E;
            4'hE:    seg = 7'h79;
            default: seg = 7'h71;
        endcase
        return seg;
    endfunction

    // Dark after reset
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            seg_n <= '1;
        end else if (cr.raw.mode) begin
            // Raw view, point stays dark
            seg_n <= {1'b1, ~cr.raw.seg};
        end else begin
            // Hex view with decimal point
            seg_n <= {~cr.hex.dp, ~hex_font(cr.hex.value)};
        end
    end

endmodule

`default_nettype wire

// File: verilog/seg7_scan.sv
// Needs SEG7_DIGITS of at least two; one digit is lit for SCAN_DIV clocks, digit 0 first
`timescale 1ns/10ps
`default_nettype none

`include "cr_params.svh"

module seg7_scan (
    input  logic                    Clk,
    input  logic                    rst_n,
    // Encoded patterns, one per digit
    input  logic [7:0]              digit_seg_n [0:`SEG7_DIGITS-1],
    // Shared active-low display bus
    output logic [7:0]              seg_n,
    output logic [`SEG7_DIGITS-1:0] an_n
);

    localparam int N     = `SEG7_DIGITS;
    localparam int DIV_W = (`SCAN_DIV > 1) ? $clog2(`SCAN_DIV) : 1;
    localparam int IDX_W = $clog2(N);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCAN_DIV - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(N - 1);

    // Dwell counter and current digit
    logic [DIV_W-1:0] div_cnt;
    logic [IDX_W-1:0] idx;

    // ------------------------------------------------------------
    // Digit sequencing
    // ------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            idx     <= '0;
        end else if (div_cnt == DIV_LAST) begin
            div_cnt <= '0;
            // Wrap after the last digit
            idx     <= (idx == IDX_LAST) ? '0 : idx + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Anode and segments registered together so they never disagree
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            seg_n <= '1;
            an_n  <= '1;
        end else begin
            seg_n <= digit_seg_n[idx];
            an_n  <= ~(N'(1) << idx);
        end
    end

endmodule

`default_nettype wire
